// File: include/pcie_write_settings.svh
`ifndef PCIE_WRITE_SETTINGS_SVH
`define PCIE_WRITE_SETTINGS_SVH

`define PW_HOST_ADDR_W 64
`define PW_HOST_RAM_ADDR_W 32
`define PW_HOST_TAG_W 8
`define PW_LEN_W 16
`define PW_DATA_W 64
`define PW_KEEP_W 8
`define PW_CORE_COUNT 4
`define PW_CORE_ADDR_W 16
`define PW_USER_W 6
`define PW_SLOT_COUNT 4
`define PW_SLOT_BYTES 64
`define PW_RAM_ADDR_W 8

// Derived widths
`define PW_CORE_W $clog2(`PW_CORE_COUNT)
`define PW_SLOT_W $clog2(`PW_SLOT_COUNT)
`define PW_SEQ_W (`PW_USER_W - `PW_CORE_W)
`define PW_BEAT_W $clog2(`PW_SLOT_BYTES / `PW_KEEP_W)
`define PW_BYTE_OFS_W $clog2(`PW_KEEP_W)

`endif

// File: rtl/pcie_write_pkg.sv
`default_nettype none
`include "pcie_write_settings.svh"

package pcie_write_pkg;

  // Write request from the host
  typedef struct packed {
    logic [`PW_HOST_ADDR_W-1:0]     host_addr;
    logic [`PW_HOST_RAM_ADDR_W-1:0] ram_addr;
    logic [`PW_LEN_W-1:0]           len;
    logic [`PW_HOST_TAG_W-1:0]      tag;
  } host_write_desc_t;

  // Control command toward one core
  typedef struct packed {
    logic [`PW_HOST_ADDR_W-1:0] host_addr;
    logic [`PW_CORE_ADDR_W-1:0] offset;
    logic [`PW_LEN_W-1:0]       len;
    logic [`PW_CORE_W-1:0]      dest;
  } core_req_t;

  typedef struct packed {
    logic [`PW_DATA_W-1:0] data;
    logic [`PW_KEEP_W-1:0] keep;
    logic [`PW_USER_W-1:0] user;
    logic                  last;
  } stream_beat_t;

  typedef struct packed {
    logic [`PW_SLOT_W-1:0] slot;
    logic [`PW_LEN_W-1:0]  len;
    logic [`PW_USER_W-1:0] user;
  } buf_status_t;

  // Tag is the slot index
  typedef struct packed {
    logic [`PW_HOST_ADDR_W-1:0] host_addr;
    logic [`PW_RAM_ADDR_W-1:0]  ram_addr;
    logic [`PW_LEN_W-1:0]       len;
    logic [`PW_SLOT_W-1:0]      tag;
  } dma_write_desc_t;

endpackage

`default_nettype wire

// File: rtl/tx_header_strip.sv
`timescale 1ns/1ns
`default_nettype none
`include "pcie_write_settings.svh"

module tx_header_strip
  import pcie_write_pkg::*;
(
  input  wire                         pcie_clk,
  input  wire                         pcie_rst,
  input  wire stream_beat_t           s_beat,
  input  wire                         s_valid,
  output logic                        s_ready,
  output logic [`PW_HOST_ADDR_W-1:0]  header,
  output logic                        header_valid,
  output stream_beat_t                m_beat,
  output logic                        m_valid,
  input  wire                         m_ready
);

  logic first_q;
  logic fire;

  // Header beat is only taken once the writer holds a slot
  assign s_ready = m_ready;
  assign fire    = s_valid && m_ready;

  assign header       = s_beat.data[`PW_HOST_ADDR_W-1:0];
  assign header_valid = fire && first_q;

  assign m_beat  = s_beat;
  assign m_valid = s_valid && !first_q;

  // Last beat rearms the header flag
  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      first_q <= 1'b1;
    end else if (fire) begin
      first_q <= s_beat.last;
    end
  end

endmodule

`default_nettype wire

// File: rtl/slot_buffer_writer.sv
`timescale 1ns/1ns
`default_nettype none
`include "pcie_write_settings.svh"

module slot_buffer_writer
  import pcie_write_pkg::*;
(
  input  wire                        pcie_clk,
  input  wire                        pcie_rst,
  input  wire                        dma_enable,
  input  wire [`PW_SLOT_W-1:0]       slot_idx,
  input  wire                        slot_valid,
  output logic                       slot_ready,
  input  wire stream_beat_t          s_beat,
  input  wire                        s_valid,
  output logic                       s_ready,
  output logic                       ram_wr_en,
  output logic [`PW_RAM_ADDR_W-1:0]  ram_wr_addr,
  output logic [`PW_DATA_W-1:0]      ram_wr_data,
  output logic [`PW_KEEP_W-1:0]      ram_wr_be,
  output buf_status_t                buf_status,
  output logic                       buf_status_valid
);

  logic                  busy_q;
  logic [`PW_SLOT_W-1:0] slot_q;
  logic [`PW_BEAT_W-1:0] beat_q;
  logic [`PW_LEN_W-1:0]  len_q;
  logic                  beat_fire;
  logic [`PW_LEN_W-1:0]  beat_bytes;

  function automatic logic [`PW_LEN_W-1:0] count_keep(input logic [`PW_KEEP_W-1:0] keep);
    logic [`PW_LEN_W-1:0] n;
    n = '0;
    for (int i = 0; i < `PW_KEEP_W; i++) begin
      n = n + keep[i];
    end
    return n;
  endfunction

  assign slot_ready = !busy_q && dma_enable;
  assign s_ready    = busy_q;
  assign beat_fire  = s_valid && busy_q;
  assign beat_bytes = count_keep(s_beat.keep);

  // Beat i of the packet lands at slot base + i*8
  assign ram_wr_en   = beat_fire;
  assign ram_wr_addr = {slot_q, beat_q, {`PW_BYTE_OFS_W{1'b0}}};
  assign ram_wr_data = s_beat.data;
  assign ram_wr_be   = s_beat.keep;

  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      busy_q           <= 1'b0;
      buf_status_valid <= 1'b0;
    end else begin
      buf_status_valid <= 1'b0;
      if (slot_valid && slot_ready) begin
        busy_q <= 1'b1;
      end
      if (beat_fire && s_beat.last) begin
        busy_q           <= 1'b0;
        buf_status_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge pcie_clk) begin
    if (slot_valid && slot_ready) begin
      slot_q <= slot_idx;
      beat_q <= '0;
      len_q  <= '0;
    end
    if (beat_fire) begin
      beat_q <= beat_q + 1'b1;
      len_q  <= len_q + beat_bytes;
    end
    if (beat_fire && s_beat.last) begin
      buf_status <= '{slot: slot_q, len: len_q + beat_bytes, user: s_beat.user};
    end
  end

endmodule

`default_nettype wire

// File: rtl/slot_scratchpad.sv
`timescale 1ns/1ns
`default_nettype none
`include "pcie_write_settings.svh"

module slot_scratchpad (
  input  wire                        pcie_clk,
  input  wire                        ram_wr_en,
  input  wire [`PW_RAM_ADDR_W-1:0]   ram_wr_addr,
  input  wire [`PW_DATA_W-1:0]       ram_wr_data,
  input  wire [`PW_KEEP_W-1:0]       ram_wr_be,
  input  wire                        ram_rd_en,
  input  wire [`PW_RAM_ADDR_W-1:0]   ram_rd_addr,
  output logic [`PW_DATA_W-1:0]      ram_rd_data
);

  // One word per beat across all slots
  logic [`PW_DATA_W-1:0] mem_q [`PW_SLOT_COUNT*`PW_SLOT_BYTES/`PW_KEEP_W];

  always_ff @(posedge pcie_clk) begin
    if (ram_wr_en) begin
      for (int b = 0; b < `PW_KEEP_W; b++) begin
        if (ram_wr_be[b]) begin
          mem_q[ram_wr_addr[`PW_RAM_ADDR_W-1:`PW_BYTE_OFS_W]][b*8 +: 8] <= ram_wr_data[b*8 +: 8];
        end
      end
    end
    if (ram_rd_en) begin
      ram_rd_data <= mem_q[ram_rd_addr[`PW_RAM_ADDR_W-1:`PW_BYTE_OFS_W]];
    end
  end

endmodule

`default_nettype wire

// File: rtl/write_desc_fifo.sv
`timescale 1ns/1ns
`default_nettype none
`include "pcie_write_settings.svh"

module write_desc_fifo
  import pcie_write_pkg::*;
(
  input  wire                    pcie_clk,
  input  wire                    pcie_rst,
  input  wire dma_write_desc_t   din,
  input  wire                    din_valid,
  output dma_write_desc_t        dout,
  output logic                   dout_valid,
  input  wire                    dout_ready
);

  dma_write_desc_t       mem_q [`PW_SLOT_COUNT];
  logic [`PW_SLOT_W-1:0] wr_ptr_q;
  logic [`PW_SLOT_W-1:0] rd_ptr_q;
  logic [`PW_SLOT_W:0]   count_q;
  logic                  out_load;
  logic                  mem_empty;
  logic                  mem_wr;
  logic                  mem_rd;

  assign mem_empty = (count_q == '0);
  assign out_load  = !dout_valid || dout_ready;
  assign mem_rd    = out_load && !mem_empty;
  // Straight into the output register when nothing is queued ahead
  assign mem_wr    = din_valid && !(out_load && mem_empty);

  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      dout_valid <= 1'b0;
    end else begin
      if (mem_wr) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (mem_rd) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_q + mem_wr - mem_rd;
      if (out_load) begin
        dout_valid <= !mem_empty || din_valid;
      end
    end
  end

  always_ff @(posedge pcie_clk) begin
    if (mem_wr) begin
      mem_q[wr_ptr_q] <= din;
    end
    if (mem_rd) begin
      dout <= mem_q[rd_ptr_q];
    end else if (out_load && din_valid) begin
      dout <= din;
    end
  end

endmodule

`default_nettype wire

// File: rtl/pcie_write_ctrl.sv
`timescale 1ns/1ns
`default_nettype none
`include "pcie_write_settings.svh"

module pcie_write_ctrl
  import pcie_write_pkg::*;
(
  input  wire                         pcie_clk,
  input  wire                         pcie_rst,
  input  wire host_write_desc_t       host_desc,
  input  wire                         host_desc_valid,
  output logic                        host_desc_ready,
  output core_req_t                   core_req,
  output logic                        core_req_valid,
  input  wire                         core_req_ready,
  output logic [`PW_HOST_TAG_W-1:0]   host_status_tag,
  output logic                        host_status_valid,
  output logic [`PW_SLOT_W-1:0]       slot_idx,
  output logic                        slot_valid,
  input  wire                         slot_ready,
  input  wire [`PW_HOST_ADDR_W-1:0]   header,
  input  wire                         header_valid,
  input  wire buf_status_t            buf_status,
  input  wire                         buf_status_valid,
  output dma_write_desc_t             fifo_din,
  output logic                        fifo_din_valid,
  input  wire [`PW_SLOT_W-1:0]        dma_done_tag,
  input  wire                         dma_done_valid
);

  // Host tag per core waiting to be returned
  logic [`PW_HOST_TAG_W-1:0]  host_tag_q [`PW_CORE_COUNT];
  logic [`PW_CORE_COUNT-1:0]  pending_q;
  // Header address and stream tag per slot
  logic [`PW_HOST_ADDR_W-1:0] slot_addr_q [`PW_SLOT_COUNT];
  logic [`PW_USER_W-1:0]      slot_user_q [`PW_SLOT_COUNT];
  logic [`PW_SLOT_COUNT-1:0]  free_q;
  logic [`PW_SLOT_COUNT-1:0]  take_mask;
  logic [`PW_SLOT_COUNT-1:0]  done_mask;
  logic [`PW_SLOT_W-1:0]      hdr_slot_q;
  logic                       hdr_wait_q;
  logic [`PW_CORE_W-1:0]      host_core;
  logic [`PW_CORE_W-1:0]      done_core;
  logic                       done_seq_zero;
  logic                       host_fire;
  logic                       slot_fire;

  assign host_core       = host_desc.ram_addr[`PW_CORE_ADDR_W +: `PW_CORE_W];
  assign host_desc_ready = core_req_ready && !pending_q[host_core];
  assign host_fire       = host_desc_valid && host_desc_ready;

  // Lowest free slot wins
  always_comb begin
    slot_idx = '0;
    for (int i = `PW_SLOT_COUNT - 1; i >= 0; i--) begin
      if (free_q[i]) begin
        slot_idx = `PW_SLOT_W'(i);
      end
    end
  end

  assign slot_valid = |free_q;
  assign slot_fire  = slot_valid && slot_ready;
  assign take_mask  = slot_fire ? (`PW_SLOT_COUNT'(1) << slot_idx) : '0;
  assign done_mask  = dma_done_valid ? (`PW_SLOT_COUNT'(1) << dma_done_tag) : '0;

  // Stream tag is {core id, sequence tag}
  assign done_core     = slot_user_q[dma_done_tag][`PW_USER_W-1 -: `PW_CORE_W];
  assign done_seq_zero = (slot_user_q[dma_done_tag][`PW_SEQ_W-1:0] == '0);

  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      free_q            <= '1;
      pending_q         <= '0;
      hdr_wait_q        <= 1'b0;
      core_req_valid    <= 1'b0;
      fifo_din_valid    <= 1'b0;
      host_status_valid <= 1'b0;
    end else begin
      // A slot is never taken and completed in the same cycle
      free_q            <= (free_q & ~take_mask) | done_mask;
      core_req_valid    <= host_fire;
      fifo_din_valid    <= buf_status_valid;
      host_status_valid <= 1'b0;
      if (dma_done_valid && done_seq_zero) begin
        host_status_valid    <= pending_q[done_core];
        pending_q[done_core] <= 1'b0;
      end
      if (host_fire) begin
        pending_q[host_core] <= 1'b1;
      end
      if (slot_fire) begin
        hdr_wait_q <= 1'b1;
      end else if (header_valid) begin
        hdr_wait_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge pcie_clk) begin
    if (host_fire) begin
      core_req <= '{host_addr: host_desc.host_addr,
                    offset:    host_desc.ram_addr[`PW_CORE_ADDR_W-1:0],
                    len:       host_desc.len,
                    dest:      host_core};
      host_tag_q[host_core] <= host_desc.tag;
    end
    if (slot_fire) begin
      hdr_slot_q <= slot_idx;
    end
    if (header_valid && hdr_wait_q) begin
      slot_addr_q[hdr_slot_q] <= header;
    end
    if (buf_status_valid) begin
      fifo_din <= '{host_addr: slot_addr_q[buf_status.slot],
                    ram_addr:  `PW_RAM_ADDR_W'(buf_status.slot * `PW_SLOT_BYTES),
                    len:       buf_status.len,
                    tag:       buf_status.slot};
      slot_user_q[buf_status.slot] <= buf_status.user;
    end
    if (dma_done_valid) begin
      host_status_tag <= host_tag_q[done_core];
    end
  end

endmodule

`default_nettype wire

// File: rtl/pcie_cont_write.sv
`timescale 1ns/1ns
`default_nettype none
`include "pcie_write_settings.svh"

module pcie_cont_write
  import pcie_write_pkg::*;
(
  input  wire                         pcie_clk,
  input  wire                         pcie_rst,
  input  wire                         dma_enable,
  input  wire host_write_desc_t       host_desc,
  input  wire                         host_desc_valid,
  output logic                        host_desc_ready,
  output logic [`PW_HOST_TAG_W-1:0]   host_status_tag,
  output logic                        host_status_valid,
  output core_req_t                   core_req,
  output logic                        core_req_valid,
  input  wire                         core_req_ready,
  input  wire stream_beat_t           core_tx_beat,
  input  wire                         core_tx_valid,
  output logic                        core_tx_ready,
  output dma_write_desc_t             dma_desc,
  output logic                        dma_desc_valid,
  input  wire                         dma_desc_ready,
  input  wire [`PW_SLOT_W-1:0]        dma_done_tag,
  input  wire                         dma_done_valid,
  input  wire                         ram_rd_en,
  input  wire [`PW_RAM_ADDR_W-1:0]    ram_rd_addr,
  output logic [`PW_DATA_W-1:0]       ram_rd_data
);

  logic [`PW_HOST_ADDR_W-1:0] header;
  logic                       header_valid;
  stream_beat_t               data_beat;
  logic                       data_valid;
  logic                       data_ready;
  logic [`PW_SLOT_W-1:0]      slot_idx;
  logic                       slot_valid;
  logic                       slot_ready;
  logic                       ram_wr_en;
  logic [`PW_RAM_ADDR_W-1:0]  ram_wr_addr;
  logic [`PW_DATA_W-1:0]      ram_wr_data;
  logic [`PW_KEEP_W-1:0]      ram_wr_be;
  buf_status_t                buf_status;
  logic                       buf_status_valid;
  dma_write_desc_t            fifo_din;
  logic                       fifo_din_valid;

  tx_header_strip strip0 (
    .pcie_clk, .pcie_rst,
    .s_beat(core_tx_beat), .s_valid(core_tx_valid), .s_ready(core_tx_ready),
    .header, .header_valid,
    .m_beat(data_beat), .m_valid(data_valid), .m_ready(data_ready)
  );

  slot_buffer_writer writer0 (
    .pcie_clk, .pcie_rst, .dma_enable,
    .slot_idx, .slot_valid, .slot_ready,
    .s_beat(data_beat), .s_valid(data_valid), .s_ready(data_ready),
    .ram_wr_en, .ram_wr_addr, .ram_wr_data, .ram_wr_be,
    .buf_status, .buf_status_valid
  );

  slot_scratchpad ram0 (
    .pcie_clk,
    .ram_wr_en, .ram_wr_addr, .ram_wr_data, .ram_wr_be,
    .ram_rd_en, .ram_rd_addr, .ram_rd_data
  );

  pcie_write_ctrl ctrl0 (
    .pcie_clk, .pcie_rst,
    .host_desc, .host_desc_valid, .host_desc_ready,
    .core_req, .core_req_valid, .core_req_ready,
    .host_status_tag, .host_status_valid,
    .slot_idx, .slot_valid, .slot_ready,
    .header, .header_valid,
    .buf_status, .buf_status_valid,
    .fifo_din, .fifo_din_valid,
    .dma_done_tag, .dma_done_valid
  );

  write_desc_fifo fifo0 (
    .pcie_clk, .pcie_rst,
    .din(fifo_din), .din_valid(fifo_din_valid),
    .dout(dma_desc), .dout_valid(dma_desc_valid), .dout_ready(dma_desc_ready)
  );

endmodule

`default_nettype wire

// File: test/pcie_cont_write_assertions.sv
`timescale 1ns/1ns
`default_nettype none
`include "pcie_write_settings.svh"

module pcie_cont_write_assertions
  import pcie_write_pkg::*;
(
  input wire                           pcie_clk,
  input wire                           pcie_rst,
  input wire host_write_desc_t         host_desc,
  input wire                           host_desc_valid,
  input wire                           host_desc_ready,
  input wire                           dma_desc_valid,
  input wire                           dma_desc_ready,
  input wire                           slot_valid,
  input wire [`PW_SLOT_W-1:0]          slot_idx,
  input wire                           slot_ready,
  input wire buf_status_t              buf_status,
  input wire                           buf_status_valid,
  input wire [`PW_SLOT_W-1:0]          dma_done_tag,
  input wire                           dma_done_valid
);

  int fail_count = 0;

  // Host tags in flight and slots in use as seen at the handshakes
  logic [`PW_CORE_COUNT-1:0] pend_q;
  logic [`PW_SLOT_COUNT-1:0] used_q;
  logic [`PW_USER_W-1:0]     user_q [`PW_SLOT_COUNT];
  logic [`PW_CORE_W-1:0]     req_core;
  logic [`PW_CORE_W-1:0]     done_core;
  logic                      done_seq_zero;

  assign req_core      = host_desc.ram_addr[`PW_CORE_ADDR_W +: `PW_CORE_W];
  assign done_core     = user_q[dma_done_tag][`PW_USER_W-1 -: `PW_CORE_W];
  assign done_seq_zero = (user_q[dma_done_tag][`PW_SEQ_W-1:0] == '0);

  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      pend_q <= '0;
      used_q <= '0;
    end else begin
      if (slot_valid && slot_ready) begin
        used_q[slot_idx] <= 1'b1;
      end
      if (dma_done_valid) begin
        used_q[dma_done_tag] <= 1'b0;
        if (done_seq_zero) begin
          pend_q[done_core] <= 1'b0;
        end
      end
      if (host_desc_valid && host_desc_ready) begin
        pend_q[req_core] <= 1'b1;
      end
    end
  end

  always_ff @(posedge pcie_clk) begin
    if (buf_status_valid) begin
      user_q[buf_status.slot] <= buf_status.user;
    end
  end

  assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    host_desc_ready |-> !pend_q[req_core])
    else begin
      fail_count++;
      $error("host request ready while core pending");
    end

  assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    dma_desc_valid && !dma_desc_ready |=> dma_desc_valid)
    else begin
      fail_count++;
      $error("DMA descriptor dropped under back-pressure");
    end

  // Offered slot must be free
  assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    slot_valid |-> !used_q[slot_idx])
    else begin
      fail_count++;
      $error("slot offered while in use");
    end

endmodule

bind pcie_cont_write pcie_cont_write_assertions asrt0 (
  .pcie_clk, .pcie_rst, .host_desc, .host_desc_valid, .host_desc_ready,
  .dma_desc_valid, .dma_desc_ready, .slot_valid, .slot_idx, .slot_ready,
  .buf_status, .buf_status_valid, .dma_done_tag, .dma_done_valid
);

`default_nettype wire

// File: test/tb_pcie_cont_write.sv
`timescale 1ns/1ns
`default_nettype none
`include "pcie_write_settings.svh"

module tb_pcie_cont_write
  import pcie_write_pkg::*;
();

  localparam int num_packets = 5;

  logic pcie_clk, pcie_rst, dma_enable;
  host_write_desc_t host_desc;
  logic host_desc_valid, host_desc_ready, host_status_valid, core_req_valid, core_req_ready;
  logic [`PW_HOST_TAG_W-1:0] host_status_tag;
  core_req_t core_req;
  stream_beat_t core_tx_beat;
  logic core_tx_valid, core_tx_ready;
  dma_write_desc_t dma_desc;
  logic dma_desc_valid, dma_desc_ready, dma_done_valid, ram_rd_en;
  logic [`PW_SLOT_W-1:0] dma_done_tag;
  logic [`PW_RAM_ADDR_W-1:0] ram_rd_addr;
  logic [`PW_DATA_W-1:0] ram_rd_data;

  logic [31:0] lfsr_q;
  int value_errors, other_errors;
  dma_write_desc_t exp_desc_q[$];
  logic [`PW_HOST_TAG_W-1:0] exp_status_q[$];
  logic [`PW_SLOT_W-1:0] done_tag_q[$];
  logic [7:0] exp_mem [256];
  logic exp_set [256];
  logic [3:0] pending;
  logic [7:0] pend_tag [4];
  logic [5:0] slot_user [4];

  pcie_cont_write dut0 (.*);

  initial begin
    pcie_clk = 1'b0;
    forever #2 pcie_clk = ~pcie_clk;
  end

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'hA3000000) : (lfsr_q >> 1);
    end
    return r;
  endfunction

  function automatic dma_write_desc_t expect_dma_desc(input logic [63:0] haddr,
      input logic [1:0] slot, input logic [63:0] keeps, input int nbeats);
    dma_write_desc_t d;
    d = '{host_addr: haddr, ram_addr: 8'(slot * 64), len: '0, tag: slot};
    for (int i = 0; i < nbeats * 8; i++) begin
      d.len = d.len + keeps[i];
    end
    return d;
  endfunction

  task automatic check_value(input string name, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp) begin
      value_errors++;
      $display("[ERROR] %0t %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic report_failure(input string msg);
    other_errors++;
    $display("%0t %s", $time, msg);
  endtask

  task automatic send_host(input logic [1:0] core, input logic [15:0] ofs,
      input logic [63:0] haddr, input logic [15:0] len, input logic [7:0] tag);
    int n;
    @(posedge pcie_clk);
    #1 host_desc = '{host_addr: haddr, ram_addr: {14'b0, core, ofs}, len: len, tag: tag};
    host_desc_valid = 1'b1;
    n = 0;
    @(negedge pcie_clk);
    while (!host_desc_ready && n < 100) begin
      @(negedge pcie_clk);
      n++;
    end
    if (!host_desc_ready) report_failure("host request was never accepted");
    @(posedge pcie_clk);
    #1 host_desc_valid = 1'b0;
    pending[core] = 1'b1;
    pend_tag[core] = tag;
    @(negedge pcie_clk);
    check_value("core_req_valid", core_req_valid, 1'b1);
    check_value("core_req", core_req, core_req_t'({haddr, ofs, len, core}));
  endtask

  task automatic send_packet(input logic [1:0] core, input logic [3:0] seq,
      input logic [63:0] haddr, input int nbeats, input logic [1:0] slot);
    stream_beat_t b;
    logic [63:0] keeps;
    int n;
    keeps = '0;
    for (int i = 0; i <= nbeats; i++) begin
      if (i == 0) begin
        b.data = haddr;
        b.keep = '1;
      end else begin
        b.data = {rand_bits(32), rand_bits(32)};
        b.keep = rand_bits(8);
      end
      b.user = {core, seq};
      b.last = (i == nbeats);
      @(posedge pcie_clk);
      #1 core_tx_beat = b;
      core_tx_valid = 1'b1;
      n = 0;
      @(negedge pcie_clk);
      while (!core_tx_ready && n < 500) begin
        @(negedge pcie_clk);
        n++;
      end
      if (!core_tx_ready) report_failure("stream beat was never accepted");
      if (i > 0) begin
        keeps[(i-1)*8 +: 8] = b.keep;
        for (int k = 0; k < 8; k++) begin
          if (b.keep[k]) begin
            exp_mem[slot*64 + (i-1)*8 + k] = b.data[k*8 +: 8];
            exp_set[slot*64 + (i-1)*8 + k] = 1'b1;
          end
        end
      end
    end
    @(posedge pcie_clk);
    #1 core_tx_valid = 1'b0;
    slot_user[slot] = {core, seq};
    exp_desc_q.push_back(expect_dma_desc(haddr, slot, keeps, nbeats));
  endtask

  // Host status follows one cycle after the completion
  // when the sequence tag is zero and a host tag is pending
  task automatic complete_next();
    int n;
    logic [1:0] s;
    logic want_status;
    n = 0;
    want_status = 1'b0;
    while (done_tag_q.size() == 0 && n < 200) begin
      @(negedge pcie_clk);
      n++;
    end
    if (done_tag_q.size() == 0) begin
      report_failure("no DMA descriptor arrived to complete");
    end else begin
      s = done_tag_q.pop_front();
      want_status = (slot_user[s][3:0] == 0) && pending[slot_user[s][5:4]];
      if (want_status) begin
        exp_status_q.push_back(pend_tag[slot_user[s][5:4]]);
        pending[slot_user[s][5:4]] = 1'b0;
      end
      @(posedge pcie_clk);
      #1 dma_done_tag = s;
      dma_done_valid = 1'b1;
      @(posedge pcie_clk);
      #1 dma_done_valid = 1'b0;
      @(negedge pcie_clk);
      check_value("host_status_valid", host_status_valid, want_status);
    end
  endtask

  initial begin
    forever begin
      @(negedge pcie_clk);
      if (dma_desc_valid && dma_desc_ready) begin
        if (exp_desc_q.size() == 0) report_failure("unexpected DMA descriptor");
        else check_value("dma_desc", dma_desc, exp_desc_q.pop_front());
        done_tag_q.push_back(dma_desc.tag);
      end
      if (host_status_valid) begin
        if (exp_status_q.size() == 0) report_failure("unexpected host status");
        else check_value("host_status_tag", host_status_tag, exp_status_q.pop_front());
      end
    end
  end

  initial begin
    #(num_packets * 200 * 4);
    $display("Watchdog expired before the tests finished");
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    lfsr_q = 32'h387e4706;
    value_errors = 0;
    other_errors = 0;
    pending = '0;
    for (int i = 0; i < 256; i++) begin
      exp_set[i] = 1'b0;
    end
    pcie_rst = 1'b1;
    dma_enable = 1'b0;
    host_desc = '0;
    host_desc_valid = 1'b0;
    core_req_ready = 1'b1;
    core_tx_beat = '0;
    core_tx_valid = 1'b0;
    dma_desc_ready = 1'b0;
    dma_done_tag = '0;
    dma_done_valid = 1'b0;
    ram_rd_en = 1'b0;
    ram_rd_addr = '0;
    repeat (4) @(posedge pcie_clk);
    #1 pcie_rst = 1'b0;
    send_host(2'd0, 16'h0100, 64'hA000_0000_0000_1000, 16'd64, 8'h11);
    send_host(2'd1, 16'h0040, 64'hB000_0000_0000_2000, 16'd24, 8'h22);
    // Core 0 still pending
    @(posedge pcie_clk);
    #1 host_desc.ram_addr = {14'b0, 2'd0, 16'h0200};
    host_desc_valid = 1'b1;
    @(negedge pcie_clk);
    check_value("host_desc_ready", host_desc_ready, 1'b0);
    @(posedge pcie_clk);
    #1 host_desc_valid = 1'b0;
    fork
      send_packet(2'd0, 4'd0, 64'hA000_0000_0000_1000, 8, 2'd0);
      begin
        repeat (10) @(negedge pcie_clk);
        check_value("core_tx_ready", core_tx_ready, 1'b0);
        @(posedge pcie_clk);
        #1 dma_enable = 1'b1;
      end
    join
    send_packet(2'd1, 4'd5, 64'hB000_0000_0000_2000, 3, 2'd1);
    send_packet(2'd1, 4'd0, 64'hB000_0000_0000_3000, 8, 2'd2);
    send_packet(2'd2, 4'd0, 64'hC000_0000_0000_4000, 1, 2'd3);
    fork
      send_packet(2'd0, 4'd3, 64'hA000_0000_0000_5000, 5, 2'd0);
      begin
        repeat (20) @(negedge pcie_clk);
        check_value("core_tx_ready", core_tx_ready, 1'b0);
        check_value("dma_desc_valid", dma_desc_valid, 1'b1);
        @(posedge pcie_clk);
        #1 dma_desc_ready = 1'b1;
        repeat (4) complete_next();
      end
    join
    send_host(2'd0, 16'h0200, 64'hA000_0000_0000_6000, 16'd8, 8'h33);
    complete_next();
    for (int w = 0; w < 32; w++) begin
      @(posedge pcie_clk);
      #1 ram_rd_en = 1'b1;
      ram_rd_addr = 8'(w * 8);
      @(posedge pcie_clk);
      #1 ram_rd_en = 1'b0;
      for (int k = 0; k < 8; k++) begin
        if (exp_set[w*8 + k]) check_value("ram_rd_data", ram_rd_data[k*8 +: 8], exp_mem[w*8 + k]);
      end
    end
    repeat (5) @(negedge pcie_clk);
    if (exp_desc_q.size() != 0 || exp_status_q.size() != 0) begin
      report_failure("expected descriptors or host statuses never arrived");
    end
    $display("value errors: %0d, other errors: %0d, assertion failures: %0d",
             value_errors, other_errors, dut0.asrt0.fail_count);
    if (value_errors == 0 && other_errors == 0 && dut0.asrt0.fail_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
+incdir+include
rtl/pcie_write_pkg.sv
rtl/tx_header_strip.sv
rtl/slot_buffer_writer.sv
rtl/slot_scratchpad.sv
rtl/write_desc_fifo.sv
rtl/pcie_write_ctrl.sv
rtl/pcie_cont_write.sv
test/pcie_cont_write_assertions.sv
test/tb_pcie_cont_write.sv

// File: Bender.yml
package:
  name: pcie_cont_write

sources:
  - include_dirs:
      - include
    files:
      - rtl/pcie_write_pkg.sv
      - rtl/tx_header_strip.sv
      - rtl/slot_buffer_writer.sv
      - rtl/slot_scratchpad.sv
      - rtl/write_desc_fifo.sv
      - rtl/pcie_write_ctrl.sv
      - rtl/pcie_cont_write.sv
      - test/pcie_cont_write_assertions.sv
      - test/tb_pcie_cont_write.sv
